/* verilog/aluPkg.sv */
`default_nettype none

package aluPkg;

    // number of one-bit slices in the datapath
    localparam int aluWidth = 32;

    // one operand or result word
    typedef logic [aluWidth-1:0] aluWord;

    // encoded command as issued by the caller
    typedef logic [2:0] aluCommand;

    // decoded command with one bit per operation
    typedef logic [7:0] aluCommandOneHot;

    // arithmetic commands use the carry chain
    localparam aluCommand cmdAdd = 3'd0;
    localparam aluCommand cmdSub = 3'd1;

    localparam aluCommand cmdXor = 3'd2;

    // signed compare, result on bit 0 only
    localparam aluCommand cmdSlt = 3'd3;

    // bitwise commands, carry chain held low
    localparam aluCommand cmdAnd  = 3'd4;
    localparam aluCommand cmdNand = 3'd5;
    localparam aluCommand cmdNor  = 3'd6;
    localparam aluCommand cmdOr   = 3'd7;

endpackage

`default_nettype wire

/* verilog/aluBitSlice.sv */
`timescale 1ns/1ns
`default_nettype none

module aluBitSlice (
    input  logic                    a,
    input  logic                    b,
    input  logic                    carryIn,
    input  aluPkg::aluCommandOneHot commandOneHot,
    output logic                    result,
    output logic                    carryOut,
    output logic                    zero
);

    // commands that go through the full adder
    logic isArith;
    // subtract and compare both add the inverted b
    logic invertB;
    logic bEffective;
    logic sum;
    logic arithCarry;
    logic logicResult;

    assign invertB = commandOneHot[aluPkg::cmdSub] | commandOneHot[aluPkg::cmdSlt];

    assign isArith = commandOneHot[aluPkg::cmdAdd]
                   | commandOneHot[aluPkg::cmdSub]
                   | commandOneHot[aluPkg::cmdSlt];

    assign bEffective = b ^ invertB;

    // full adder
    assign sum        = a ^ bEffective ^ carryIn;
    assign arithCarry = (a & bEffective) | (a & carryIn) | (bEffective & carryIn);

    // bitwise functions, only one command bit is set at a time
    always_comb begin
        logicResult = 1'b0;
        unique case (1'b1)
            commandOneHot[aluPkg::cmdXor]: begin
                logicResult = a ^ b;
            end
            commandOneHot[aluPkg::cmdAnd]: begin
                logicResult = a & b;
            end
            commandOneHot[aluPkg::cmdNand]: begin
                logicResult = ~(a & b);
            end
            commandOneHot[aluPkg::cmdNor]: begin
                logicResult = ~(a | b);
            end
            commandOneHot[aluPkg::cmdOr]: begin
                logicResult = a | b;
            end
            default: begin
                logicResult = 1'b0;
            end
        endcase
    end

    // pick the adder or the logic path for this bit
    always_comb begin
        if (isArith) begin
            result   = sum;
            carryOut = arithCarry;
        end else begin
            result   = logicResult;
            // no carry leaves a logic slice
            carryOut = 1'b0;
        end
    end

    // combined across all slices by the word level
    assign zero = ~result;

endmodule

`default_nettype wire

/* verilog/alu.sv */
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  aluPkg::aluWord    operandA,
    input  aluPkg::aluWord    operandB,
    input  aluPkg::aluCommand command,
    output aluPkg::aluWord    result,
    output logic              carryout,
    output logic              zero,
    output logic              overflow
);

    aluPkg::aluCommandOneHot commandOneHot;

    // carryBus[i] feeds slice i, top entry is the final carry
    logic [aluPkg::aluWidth:0] carryBus;

    aluPkg::aluWord sliceResult;
    aluPkg::aluWord sliceZero;
    aluPkg::aluWord overrideBus;
    aluPkg::aluWord finalZero;

    logic isAddSub;
    logic isSlt;
    logic subtracting;
    logic signA;
    logic signBEffective;
    logic signSum;
    logic rawOverflow;
    logic sltBit;

    // one-hot decode of the command code
    always_comb begin
        commandOneHot = '0;
        case (command)
            aluPkg::cmdAdd:  commandOneHot[aluPkg::cmdAdd]  = 1'b1;
            aluPkg::cmdSub:  commandOneHot[aluPkg::cmdSub]  = 1'b1;
            aluPkg::cmdXor:  commandOneHot[aluPkg::cmdXor]  = 1'b1;
            aluPkg::cmdSlt:  commandOneHot[aluPkg::cmdSlt]  = 1'b1;
            aluPkg::cmdAnd:  commandOneHot[aluPkg::cmdAnd]  = 1'b1;
            aluPkg::cmdNand: commandOneHot[aluPkg::cmdNand] = 1'b1;
            aluPkg::cmdNor:  commandOneHot[aluPkg::cmdNor]  = 1'b1;
            aluPkg::cmdOr:   commandOneHot[aluPkg::cmdOr]   = 1'b1;
            default:         commandOneHot = '0;
        endcase
    end

    assign isSlt       = commandOneHot[aluPkg::cmdSlt];
    assign isAddSub    = commandOneHot[aluPkg::cmdAdd] | commandOneHot[aluPkg::cmdSub];
    assign subtracting = commandOneHot[aluPkg::cmdSub] | isSlt;

    // two's complement subtract needs the extra one at the bottom
    assign carryBus[0] = subtracting;

    // ripple-carry slice chain
    for (genvar i = 0; i < aluPkg::aluWidth; i++) begin : sliceGen
        aluBitSlice slice (
            .a             (operandA[i]),
            .b             (operandB[i]),
            .carryIn       (carryBus[i]),
            .commandOneHot (commandOneHot),
            .result        (sliceResult[i]),
            .carryOut      (carryBus[i+1]),
            .zero          (sliceZero[i])
        );
    end

    // logic slices already hold their carry low
    assign carryout = carryBus[aluPkg::aluWidth];

    // signed overflow from the operand signs and the sum sign
    assign signA          = operandA[aluPkg::aluWidth-1];
    assign signBEffective = operandB[aluPkg::aluWidth-1] ^ subtracting;
    assign signSum        = sliceResult[aluPkg::aluWidth-1];

    // same input signs but the sum sign flipped
    assign rawOverflow = (signA == signBEffective) && (signSum != signA);

    // only add and subtract report it
    assign overflow = rawOverflow & isAddSub;

    // true sign of a - b even when the difference wrapped
    assign sltBit = signSum ^ rawOverflow;

    // compare result sits on bit 0 with the rest cleared
    assign overrideBus = {{(aluPkg::aluWidth-1){1'b0}}, sltBit};

    assign result = isSlt ? overrideBus : sliceResult;

    // zero bits of whatever word actually leaves the ALU
    assign finalZero = isSlt ? ~overrideBus : sliceZero;

    assign zero = &finalZero;

endmodule

`default_nettype wire

/* verilog/aluUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnit (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  aluPkg::aluWord    operandA,
    input  aluPkg::aluWord    operandB,
    input  aluPkg::aluCommand command,
    output logic              done,
    output aluPkg::aluWord    result,
    output logic              carryout,
    output logic              zero,
    output logic              overflow
);

    // combinational ALU outputs for the operands at the inputs
    aluPkg::aluWord aluResult;
    logic           aluCarryout;
    logic           aluZero;
    logic           aluOverflow;

    alu aluCore (
        .operandA (operandA),
        .operandB (operandB),
        .command  (command),
        .result   (aluResult),
        .carryout (aluCarryout),
        .zero     (aluZero),
        .overflow (aluOverflow)
    );

    // done follows start by one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            done <= 1'b0;
        end else begin
            done <= start;
        end
    end

    // capture the outputs only for a strobed operation
    always_ff @(posedge clk) begin
        if (reset) begin
            result   <= '0;
            carryout <= 1'b0;
            zero     <= 1'b0;
            overflow <= 1'b0;
        end else if (start) begin
            result   <= aluResult;
            carryout <= aluCarryout;
            zero     <= aluZero;
            overflow <= aluOverflow;
        end
    end

endmodule

`default_nettype wire

/* verification/aluUnit_asserts.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnitAsserts (
    input logic              clk,
    input logic              reset,
    input logic              start,
    input aluPkg::aluCommand command,
    input logic              done,
    input aluPkg::aluWord    result,
    input logic              carryout,
    input logic              zero,
    input logic              overflow
);

    // read by the testbench at the end of the run
    int violationCount = 0;

    logic logicCommand;
    logic sltCommand;

    assign logicCommand = (command == aluPkg::cmdXor)
                        | (command == aluPkg::cmdAnd)
                        | (command == aluPkg::cmdNand)
                        | (command == aluPkg::cmdNor)
                        | (command == aluPkg::cmdOr);

    assign sltCommand = (command == aluPkg::cmdSlt);

    // done stays low in the cycle after any reset edge
    doneLowAfterReset: assert property (@(posedge clk) reset |=> !done)
        else begin
            violationCount++;
            $error("done was high right after a reset cycle");
        end

    // every strobe gives a done one cycle later, back to back included
    doneFollowsStart: assert property (@(posedge clk) disable iff (reset) start |=> done)
        else begin
            violationCount++;
            $error("done did not follow start by one cycle");
        end

    noSpuriousDone: assert property (@(posedge clk) disable iff (reset) !start |=> !done)
        else begin
            violationCount++;
            $error("done was raised without a start in the cycle before");
        end

    zeroMatchesResult: assert property (@(posedge clk) disable iff (reset)
        done |-> (zero == (result == '0)))
        else begin
            violationCount++;
            $error("zero flag does not match the result being all zeros");
        end

    // bitwise commands never touch the carry chain flags
    logicFlagsLow: assert property (@(posedge clk) disable iff (reset)
        start && logicCommand |=> !carryout && !overflow)
        else begin
            violationCount++;
            $error("carryout or overflow set for a logic command");
        end

    sltUpperBitsClear: assert property (@(posedge clk) disable iff (reset)
        start && sltCommand |=> (result[aluPkg::aluWidth-1:1] == '0) && !overflow)
        else begin
            violationCount++;
            $error("set-less-than left upper result bits or overflow set");
        end

endmodule

bind aluUnit aluUnitAsserts timingChecks (.*);

`default_nettype wire

/* verification/aluUnitTb.sv */
`timescale 1ns/1ns
`default_nettype none

module aluUnitTb;

    localparam int clkPeriod     = 20;
    localparam int resetCycles   = 5;
    localparam int directedOps   = 23;
    localparam int randomOps     = 300;
    localparam int maxGap        = 3;
    // each directed op takes at most two cycles, each random op up to 1 + maxGap
    localparam int watchdogCycles = resetCycles + 2 * directedOps
                                  + randomOps * (maxGap + 1) + 20;

    // test group ids, printed through testLabel
    localparam int tAddSub   = 0;
    localparam int tOverflow = 1;
    localparam int tSlt      = 2;
    localparam int tLogic    = 3;
    localparam int tRandom   = 4;

    logic              clk;
    logic              reset;
    logic              start;
    aluPkg::aluWord    operandA;
    aluPkg::aluWord    operandB;
    aluPkg::aluCommand command;
    logic              done;
    aluPkg::aluWord    result;
    logic              carryout;
    logic              zero;
    logic              overflow;

    // group of the operation on the inputs, sampled with start
    int opTestId;
    int issuedOps = 0;
    integer seed;

    // expected outputs, one entry per outstanding operation
    aluPkg::aluWord resultQ [$];
    logic           carryQ [$];
    logic           overflowQ [$];
    int             testIdQ [$];

    // front of the queue, compared while done is high
    aluPkg::aluWord expResult = '0;
    logic           expCarry = 1'b0;
    logic           expZero = 1'b0;
    logic           expOverflow = 1'b0;
    int             expTestId = 0;

    int resultErrors = 0;
    int carryErrors = 0;
    int zeroErrors = 0;
    int overflowErrors = 0;
    int orphanErrors = 0;

    aluUnit uut (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .operandA (operandA),
        .operandB (operandB),
        .command  (command),
        .done     (done),
        .result   (result),
        .carryout (carryout),
        .zero     (zero),
        .overflow (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic string testLabel(input int id);
        case (id)
            tAddSub:   return "addsub";
            tOverflow: return "overflow";
            tSlt:      return "slt";
            tLogic:    return "logic";
            default:   return "random";
        endcase
    endfunction

    // reference model written from the command rules
    task automatic modelOp(
        input  aluPkg::aluWord    a,
        input  aluPkg::aluWord    b,
        input  aluPkg::aluCommand cmd,
        output aluPkg::aluWord    res,
        output logic              carry,
        output logic              ovf
    );
        logic [aluPkg::aluWidth:0] wide;
        logic [aluPkg::aluWidth:0] exact;
        int msb;
        msb   = aluPkg::aluWidth - 1;
        wide  = '0;
        exact = '0;
        res   = '0;
        carry = 1'b0;
        ovf   = 1'b0;
        case (cmd)
            aluPkg::cmdAdd: begin
                wide  = {1'b0, a} + {1'b0, b};
                exact = {a[msb], a} + {b[msb], b};
                res   = wide[aluPkg::aluWidth-1:0];
                carry = wide[aluPkg::aluWidth];
                // the sign-extended sum no longer fits in one word
                ovf   = exact[aluPkg::aluWidth] != exact[msb];
            end
            aluPkg::cmdSub: begin
                wide  = {1'b0, a} - {1'b0, b};
                exact = {a[msb], a} - {b[msb], b};
                res   = wide[aluPkg::aluWidth-1:0];
                // carry out of the two's complement chain means no borrow
                carry = ~wide[aluPkg::aluWidth];
                ovf   = exact[aluPkg::aluWidth] != exact[msb];
            end
            aluPkg::cmdSlt: begin
                // carry still comes from the a - b chain
                wide   = {1'b0, a} - {1'b0, b};
                carry  = ~wide[aluPkg::aluWidth];
                res[0] = ($signed(a) < $signed(b));
            end
            aluPkg::cmdXor:  res = a ^ b;
            aluPkg::cmdAnd:  res = a & b;
            aluPkg::cmdNand: res = ~(a & b);
            aluPkg::cmdNor:  res = ~(a | b);
            default:         res = a | b;
        endcase
    endtask

    // queue on start, retire on done
    always @(posedge clk) begin
        aluPkg::aluWord modelResult;
        logic           modelCarry;
        logic           modelOverflow;
        if (reset) begin
            resultQ.delete();
            carryQ.delete();
            overflowQ.delete();
            testIdQ.delete();
        end else begin
            if (done) begin
                if (resultQ.size() == 0) begin
                    orphanErrors++;
                    $display("done was raised with no operation outstanding");
                end else begin
                    void'(resultQ.pop_front());
                    void'(carryQ.pop_front());
                    void'(overflowQ.pop_front());
                    void'(testIdQ.pop_front());
                end
            end
            if (start) begin
                modelOp(operandA, operandB, command, modelResult, modelCarry, modelOverflow);
                resultQ.push_back(modelResult);
                carryQ.push_back(modelCarry);
                overflowQ.push_back(modelOverflow);
                testIdQ.push_back(opTestId);
            end
            if (resultQ.size() != 0) begin
                expResult   = resultQ[0];
                expCarry    = carryQ[0];
                expZero     = (resultQ[0] == '0);
                expOverflow = overflowQ[0];
                expTestId   = testIdQ[0];
            end
        end
    end

    resultCheck: assert property (@(posedge clk) disable iff (reset)
        done |-> (result == expResult))
        else begin
            resultErrors++;
            $display("ERROR %s result expected %h actual %h",
                     testLabel($sampled(expTestId)), $sampled(expResult), $sampled(result));
        end

    carryCheck: assert property (@(posedge clk) disable iff (reset)
        done |-> (carryout == expCarry))
        else begin
            carryErrors++;
            $display("ERROR %s carryout expected %b actual %b",
                     testLabel($sampled(expTestId)), $sampled(expCarry), $sampled(carryout));
        end

    zeroCheck: assert property (@(posedge clk) disable iff (reset)
        done |-> (zero == expZero))
        else begin
            zeroErrors++;
            $display("ERROR %s zero expected %b actual %b",
                     testLabel($sampled(expTestId)), $sampled(expZero), $sampled(zero));
        end

    overflowCheck: assert property (@(posedge clk) disable iff (reset)
        done |-> (overflow == expOverflow))
        else begin
            overflowErrors++;
            $display("ERROR %s overflow expected %b actual %b",
                     testLabel($sampled(expTestId)), $sampled(expOverflow), $sampled(overflow));
        end

    task automatic issueOp(
        input int                id,
        input aluPkg::aluWord    a,
        input aluPkg::aluWord    b,
        input aluPkg::aluCommand cmd
    );
        @(posedge clk);
        start    <= 1'b1;
        operandA <= a;
        operandB <= b;
        command  <= cmd;
        opTestId <= id;
        issuedOps++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    initial begin
        #(watchdogCycles * clkPeriod);
        $display("timeout: run did not finish within %0d cycles", watchdogCycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        aluPkg::aluCommand logicCmds [5];
        aluPkg::aluWord    a;
        aluPkg::aluWord    b;
        aluPkg::aluCommand cmd;
        logic [31:0]       rnd;
        int                totalErrors;
        logicCmds = '{aluPkg::cmdXor, aluPkg::cmdAnd, aluPkg::cmdNand,
                      aluPkg::cmdNor, aluPkg::cmdOr};
        seed     = 32'h9ad7_93aa;
        reset    = 1'b1;
        start    = 1'b0;
        operandA = '0;
        operandB = '0;
        command  = aluPkg::cmdAdd;
        opTestId = 0;
        repeat (resetCycles) @(posedge clk);
        reset <= 1'b0;

        // wrap-around on add and subtract
        issueOp(tAddSub, 32'hffff_ffff, 32'h0000_0001, aluPkg::cmdAdd);
        issueOp(tAddSub, 32'h0000_0000, 32'h0000_0001, aluPkg::cmdSub);
        issueOp(tAddSub, 32'd5, 32'd7, aluPkg::cmdAdd);
        issueOp(tAddSub, 32'd100, 32'd42, aluPkg::cmdSub);
        issueOp(tAddSub, 32'h1234_5678, 32'h1234_5678, aluPkg::cmdSub);
        idleCycles(1);

        issueOp(tOverflow, 32'h7fff_ffff, 32'h0000_0001, aluPkg::cmdAdd);
        issueOp(tOverflow, 32'h8000_0000, 32'h0000_0001, aluPkg::cmdSub);
        issueOp(tOverflow, 32'h8000_0000, 32'h8000_0000, aluPkg::cmdAdd);
        idleCycles(1);

        // negative/positive, positive/negative, equal, and the wrapping pair
        issueOp(tSlt, 32'hffff_fffb, 32'd3, aluPkg::cmdSlt);
        issueOp(tSlt, 32'd3, 32'hffff_fffb, aluPkg::cmdSlt);
        issueOp(tSlt, 32'd9, 32'd9, aluPkg::cmdSlt);
        issueOp(tSlt, 32'h8000_0000, 32'h7fff_ffff, aluPkg::cmdSlt);
        issueOp(tSlt, 32'h7fff_ffff, 32'h8000_0000, aluPkg::cmdSlt);
        idleCycles(1);

        for (int i = 0; i < 5; i++) begin
            issueOp(tLogic, 32'hf0f0_a5a5, 32'hff00_5a5a, logicCmds[i]);
            issueOp(tLogic, 32'h0000_0000, 32'hffff_ffff, logicCmds[i]);
        end
        idleCycles(1);

        for (int n = 0; n < randomOps; n++) begin
            rnd = $random(seed);
            a   = rnd;
            rnd = $random(seed);
            b   = rnd;
            rnd = $random(seed);
            cmd = rnd[2:0];
            // equal operands now and then, to reach zero results
            if (rnd[7:4] == 4'd0) begin
                b = a;
            end
            issueOp(tRandom, a, b, cmd);
            idleCycles(int'(rnd[9:8]));
        end
        idleCycles(1);

        // drain whatever is still outstanding, the watchdog bounds this
        @(negedge clk);
        while (resultQ.size() != 0) begin
            @(negedge clk);
        end
        // one more edge so the last one-cycle-later checks complete
        @(negedge clk);

        totalErrors = resultErrors + carryErrors + zeroErrors + overflowErrors
                    + orphanErrors + uut.timingChecks.violationCount;
        $display("errors: res %0d carry %0d zero %0d ovf %0d orphan %0d bound %0d ops %0d",
                 resultErrors, carryErrors, zeroErrors, overflowErrors, orphanErrors,
                 uut.timingChecks.violationCount, issuedOps);
        if (totalErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
verilog/aluPkg.sv
verilog/aluBitSlice.sv
verilog/alu.sv
verilog/aluUnit.sv
verification/aluUnit_asserts.sv
verification/aluUnitTb.sv

/* run.sh */
#!/bin/sh
# build and run the ALU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module aluUnitTb \
    -f all.f \
    --Mdir obj_dir

# keep running past assertion failures so the testbench can report them
output=$(./obj_dir/ValuUnitTb +verilator+error+limit+10000 2>&1) || true
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1
